/* rtl/DataMemory.sv */
`timescale 1ns/1ps
`include "lsu_defs.svh"

module DataMemory import lsuPkg::*; (
    input  logic     Clock,
    input  word_t    address,
    input  word_t    writeData,  // rt contents for stores
    input  logic     memWrite,
    input  logic     memRead,
    input  accSize_t accSize,
    input  logic     signedLoad, // Clear for lhu and lbu
    output word_t    readData
);

    localparam int IdxW = $clog2(`MEM_WORDS);

    word_t            mem [`MEM_WORDS];
    logic [IdxW-1:0]  wordIdx;
    logic [1:0]       lane;       // Byte offset within the word
    logic [3:0]       byteEn;
    word_t            laneData;   // Store data replicated onto its lanes
    word_t            rdWord;
    logic [15:0]      rdHalf;
    logic [7:0]       rdByte;

    // Word address, wraps modulo memory size
    assign wordIdx = address[IdxW+1:2];
    assign lane    = address[1:0];

    // Memory image starts cleared
    initial begin
        for (int i = 0; i < `MEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // Lane enables and data placement
    always_comb begin
        byteEn   = 4'b0000;
        laneData = writeData;
        case (accSize)
            sizeWord: byteEn = 4'b1111;
            sizeHalf: begin
                byteEn   = lane[1] ? 4'b1100 : 4'b0011;  // Upper or lower half
                laneData = {writeData[15:0], writeData[15:0]};
            end
            sizeByte: begin
                byteEn   = 4'b0001 << lane;
                laneData = {4{writeData[7:0]}};
            end
            default:  byteEn = 4'b0000;
        endcase
    end

    // Store on the edge, untouched lanes keep their bytes
    always @(posedge Clock) begin
        if (memWrite) begin
            for (int b = 0; b < 4; b++) begin
                if (byteEn[b])
                    mem[wordIdx][8*b +: 8] <= laneData[8*b +: 8];
            end
        end
    end

    // Load path, combinational
    assign rdWord = mem[wordIdx];
    assign rdHalf = lane[1] ? rdWord[31:16] : rdWord[15:0];
    assign rdByte = rdWord[8*lane +: 8];

    always_comb begin
        readData = '0;  // Idle bus reads zero
        if (memRead) begin
            case (accSize)
                sizeWord: readData = rdWord;
                sizeHalf: readData = {{16{signedLoad & rdHalf[15]}}, rdHalf};
                sizeByte: readData = {{24{signedLoad & rdByte[7]}}, rdByte};
                default:  readData = '0;
            endcase
        end
    end

endmodule

/* rtl/addrGen.sv */
`timescale 1ns/1ps

module addrGen import lsuPkg::*; (
    input  word_t       base,      // rs contents
    input  logic [15:0] imm,
    input  accSize_t    accSize,
    output word_t       effAddr,
    output logic        misaligned
);

    word_t offset;
    logic  halfBad;
    logic  wordBad;

    // Sign extend the 16-bit offset
    assign offset = {{16{imm[15]}}, imm};

    // Also serves as the addiu result
    assign effAddr = base + offset;

    // Halfword needs bit 0 clear
    assign halfBad = (accSize == sizeHalf) & effAddr[0];

    // Word needs both low bits clear
    assign wordBad = (accSize == sizeWord) & (|effAddr[1:0]);

    assign misaligned = halfBad | wordBad;  // Bytes always fine

endmodule

/* rtl/loadStoreUnit.sv */
`timescale 1ns/1ps

module loadStoreUnit import lsuPkg::*; (
    input  logic   Clock,
    input  logic   rstN,
    input  instr_t instr,
    input  logic   instrValid,
    output word_t  wbData,
    output word_t  effAddr,
    output logic   regWrite,
    output logic   misaligned
);

    regIdx_t     rsIdx;
    regIdx_t     rtIdx;
    logic [15:0] imm;
    accSize_t    accSize;
    logic        signedLoad;
    logic        memWrite;
    logic        memRead;
    logic        wbFromMem;
    word_t       rsData;
    word_t       rtData;
    word_t       readData;

    // Decode, gated by valid and misalignment
    lsDecode lsDecode_i (
        .instr      (instr),
        .instrValid (instrValid),
        .misaligned (misaligned),
        .rsIdx      (rsIdx),
        .rtIdx      (rtIdx),
        .imm        (imm),
        .accSize    (accSize),
        .signedLoad (signedLoad),
        .memWrite   (memWrite),
        .memRead    (memRead),
        .regWrite   (regWrite),
        .wbFromMem  (wbFromMem)
    );

    addrGen addrGen_i (
        .base       (rsData),
        .imm        (imm),
        .accSize    (accSize),
        .effAddr    (effAddr),
        .misaligned (misaligned)
    );

    DataMemory dataMemory_i (
        .Clock      (Clock),
        .address    (effAddr),
        .writeData  (rtData),     // Store source is rt
        .memWrite   (memWrite),
        .memRead    (memRead),
        .accSize    (accSize),
        .signedLoad (signedLoad),
        .readData   (readData)
    );

    regFile regFile_i (
        .Clock     (Clock),
        .rstN      (rstN),
        .rsIdx     (rsIdx),
        .rtIdx     (rtIdx),
        .regWrite  (regWrite),
        .wbFromMem (wbFromMem),
        .memData   (readData),
        .aluData   (effAddr),      // addiu result shares the adder
        .rsData    (rsData),
        .rtData    (rtData),
        .wbData    (wbData)
    );

endmodule

/* rtl/lsDecode.sv */
`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsDecode import lsuPkg::*; (
    input  instr_t   instr,
    input  logic     instrValid,
    input  logic     misaligned,  // From addrGen, same cycle
    output regIdx_t  rsIdx,
    output regIdx_t  rtIdx,
    output logic [15:0] imm,
    output accSize_t accSize,
    output logic     signedLoad,
    output logic     memWrite,
    output logic     memRead,
    output logic     regWrite,
    output logic     wbFromMem
);

    opcode_t opcode;
    logic    isLoad;   // Any lw/lh/lhu/lb/lbu
    logic    isStore;  // Any sw/sh/sb
    logic    isAddiu;

    // Field split
    assign opcode = instr[31:26];
    assign rsIdx  = instr[25:21];
    assign rtIdx  = instr[20:16];
    assign imm    = instr[15:0];

    always_comb begin
        isLoad     = 1'b0;
        isStore    = 1'b0;
        isAddiu    = 1'b0;
        signedLoad = 1'b0;
        accSize    = sizeByte;  // Byte never flags misalignment, safe for non-memory ops
        case (opcode)
            `OP_LW:    begin isLoad  = 1'b1; accSize = sizeWord; signedLoad = 1'b1; end
            `OP_LH:    begin isLoad  = 1'b1; accSize = sizeHalf; signedLoad = 1'b1; end
            `OP_LHU:   begin isLoad  = 1'b1; accSize = sizeHalf; end
            `OP_LB:    begin isLoad  = 1'b1; signedLoad = 1'b1; end
            `OP_LBU:   isLoad  = 1'b1;
            `OP_SW:    begin isStore = 1'b1; accSize = sizeWord; end
            `OP_SH:    begin isStore = 1'b1; accSize = sizeHalf; end
            `OP_SB:    isStore = 1'b1;
            `OP_ADDIU: isAddiu = 1'b1;
            default:   ;  // Unknown opcode, everything stays idle
        endcase
    end

    // Single gating point for all side effects
    assign memRead   = isLoad;
    assign wbFromMem = isLoad;
    assign memWrite  = instrValid & isStore & ~misaligned;  // Misaligned store dropped
    assign regWrite  = instrValid & (isAddiu | (isLoad & ~misaligned));

endmodule

/* rtl/lsuPkg.sv */
package lsuPkg;

    // Data and address words
    typedef logic [31:0] word_t;

    // Register file index, 32 entries
    typedef logic [4:0] regIdx_t;

    // Raw I-type instruction: op, rs, rt, imm16
    typedef logic [31:0] instr_t;

    typedef logic [5:0] opcode_t;  // Instruction bits 31:26

    // Access width of a load or store
    typedef enum logic [1:0] {
        sizeWord = 2'b00,
        sizeHalf = 2'b01,
        sizeByte = 2'b10
    } accSize_t;

endpackage

/* rtl/lsu_defs.svh */
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// Memory size in 32-bit words, byte addresses wrap at 4x this
`define MEM_WORDS 1024
`define NUM_REGS  32

// Standard MIPS I-type opcodes
`define OP_ADDIU 6'h09
`define OP_LB    6'h20
`define OP_LH    6'h21
`define OP_LW    6'h23
`define OP_LBU   6'h24
`define OP_LHU   6'h25
`define OP_SB    6'h28
`define OP_SH    6'h29
`define OP_SW    6'h2B

`endif

/* rtl/regFile.sv */
`timescale 1ns/1ps
`include "lsu_defs.svh"

module regFile import lsuPkg::*; (
    input  logic    Clock,
    input  logic    rstN,
    input  regIdx_t rsIdx,
    input  regIdx_t rtIdx,     // Read port and write target
    input  logic    regWrite,
    input  logic    wbFromMem,
    input  word_t   memData,   // Extended load data
    input  word_t   aluData,   // addiu sum
    output word_t   rsData,
    output word_t   rtData,
    output word_t   wbData
);

    word_t regs [`NUM_REGS];
    logic  doWrite;

    // Writeback mux
    assign wbData = wbFromMem ? memData : aluData;

    // r0 is never written
    assign doWrite = regWrite & (rtIdx != '0);

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (doWrite) begin
            regs[rtIdx] <= wbData;
        end
    end

    // Reads are combinational, r0 forced to zero
    assign rsData = (rsIdx == '0) ? '0 : regs[rsIdx];
    assign rtData = (rtIdx == '0) ? '0 : regs[rtIdx];

endmodule

/* sim.f */
+incdir+rtl
rtl/lsuPkg.sv
rtl/lsDecode.sv
rtl/addrGen.sv
rtl/DataMemory.sv
rtl/regFile.sv
rtl/loadStoreUnit.sv
verification/lsu_chk.sv
verification/lsuTb.sv

/* verification/lsuTb.sv */
`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsuTb import lsuPkg::*; ();

    localparam int ClkPeriod   = 10;
    localparam int ResetCycles = 16;
    localparam int NumDirected = 48;   // Upper bound on directed instructions
    localparam int NumRand     = 400;
    localparam int TimeoutNs   = (ResetCycles + NumDirected + NumRand + 20) * ClkPeriod;

    logic   Clock = 1'b0;
    logic   rstN;
    instr_t instr;
    logic   instrValid;
    word_t  wbData;
    word_t  effAddr;
    logic   regWrite;
    logic   misaligned;

    // Reference state, little-endian byte image
    word_t      modelRegs [`NUM_REGS];
    logic [7:0] modelMem  [`MEM_WORDS * 4];

    int    wordErrs   = 0;
    int    flagErrs   = 0;
    int    checkCount = 0;
    int    totalErrs;
    word_t expWb;
    logic  expWr;
    word_t expAddr;
    logic  expMis;

    // Random opcode pool, 0x0F is lui and not decoded here
    opcode_t opList [10] = '{`OP_LW, `OP_LH, `OP_LHU, `OP_LB, `OP_LBU,
                             `OP_SW, `OP_SH, `OP_SB, `OP_ADDIU, 6'h0F};

    loadStoreUnit loadStoreUnit_i (
        .Clock      (Clock),
        .rstN       (rstN),
        .instr      (instr),
        .instrValid (instrValid),
        .wbData     (wbData),
        .effAddr    (effAddr),
        .regWrite   (regWrite),
        .misaligned (misaligned)
    );

    always #(ClkPeriod / 2) Clock = ~Clock;

    function automatic instr_t buildInstr(opcode_t op, regIdx_t rs, regIdx_t rt,
                                          logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // Expected outputs from current state, then advance the model one edge
    function automatic void refExec(
        input  instr_t ins,
        input  logic   valid,
        output word_t  wb,
        output logic   wr,
        output word_t  addr,
        output logic   mis
    );
        opcode_t op;
        regIdx_t rs;
        regIdx_t rt;
        word_t   rtVal;
        word_t   ld;
        int      nBytes;
        int      base;
        logic    isLoad;
        logic    isStore;
        op      = ins[31:26];
        rs      = ins[25:21];
        rt      = ins[20:16];
        rtVal   = (rt == 0) ? '0 : modelRegs[rt];
        isLoad  = op inside {`OP_LW, `OP_LH, `OP_LHU, `OP_LB, `OP_LBU};
        isStore = op inside {`OP_SW, `OP_SH, `OP_SB};
        if (op inside {`OP_LW, `OP_SW})
            nBytes = 4;
        else if (op inside {`OP_LH, `OP_LHU, `OP_SH})
            nBytes = 2;
        else
            nBytes = 1;                           // Bytes and non-memory ops
        addr = ((rs == 0) ? '0 : modelRegs[rs]) + {{16{ins[15]}}, ins[15:0]};
        mis  = (nBytes == 2 && addr[0]) || (nBytes == 4 && addr[1:0] != 2'b00);
        base = int'(addr % (`MEM_WORDS * 4));     // Wraps over the byte image
        base = base - (base % nBytes);            // Memory reads the aligned container
        ld   = '0;
        for (int k = 0; k < nBytes; k++)
            ld[8*k +: 8] = modelMem[base + k];
        if (op == `OP_LH)
            ld[31:16] = {16{ld[15]}};
        if (op == `OP_LB)
            ld[31:8] = {24{ld[7]}};
        wr = valid && ((op == `OP_ADDIU) || (isLoad && !mis));
        wb = isLoad ? ld : addr;
        if (wr && rt != 0)
            modelRegs[rt] = wb;
        if (valid && isStore && !mis) begin   // Misaligned store dropped
            for (int k = 0; k < nBytes; k++)
                modelMem[base + k] = rtVal[8*k +: 8];
        end
    endfunction

    task automatic checkWord(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            wordErrs++;
            $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic checkFlag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            flagErrs++;
            $display("error at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // Outputs settled since the falling edge
    always @(posedge Clock) begin
        if (rstN) begin
            refExec(instr, instrValid, expWb, expWr, expAddr, expMis);
            checkFlag("regWrite", regWrite, expWr);
            checkWord("effAddr", effAddr, expAddr);
            checkFlag("misaligned", misaligned, expMis);
            if (expWr)
                checkWord("wbData", wbData, expWb);  // Only meaningful on a write
            checkCount++;
        end
    end

    task automatic issueInstr(input instr_t ins);
        @(negedge Clock);
        instr      = ins;
        instrValid = 1'b1;
    endtask

    task automatic idleCycle(input instr_t ins);
        @(negedge Clock);
        instr      = ins;   // Decoded but must have no effect
        instrValid = 1'b0;
    endtask

    // Bases r1..r3 stay fixed, data goes to r0 and r4..r9
    function automatic instr_t randomInstr();
        opcode_t     op;
        regIdx_t     rs;
        regIdx_t     rt;
        logic [15:0] imm;
        op  = opList[$urandom % 10];
        rs  = regIdx_t'(1 + $urandom % 3);
        rt  = ($urandom % 7 == 0) ? 5'd0 : regIdx_t'(4 + $urandom % 6);
        imm = 16'($urandom % 64) - 16'd32;   // Small window around each base
        if (op == `OP_ADDIU)
            rs = regIdx_t'($urandom % 10);
        return buildInstr(op, rs, rt, imm);
    endfunction

    task automatic runDirected();
        // addiu incl. negative offsets and r0
        issueInstr(buildInstr(`OP_ADDIU, 0, 1, 16'h0100));
        issueInstr(buildInstr(`OP_ADDIU, 1, 2, 16'hFFF0));
        issueInstr(buildInstr(`OP_ADDIU, 0, 3, 16'hFFFC));  // Base below zero
        issueInstr(buildInstr(`OP_ADDIU, 1, 0, 16'h0005));
        issueInstr(buildInstr(`OP_ADDIU, 0, 4, 16'h0007));  // r0 must still read zero
        issueInstr(buildInstr(`OP_ADDIU, 0, 5, 16'h1234));
        issueInstr(buildInstr(`OP_ADDIU, 0, 6, 16'h8765));
        // Word round trip
        issueInstr(buildInstr(`OP_SW, 1, 6, 16'h0000));
        issueInstr(buildInstr(`OP_LW, 1, 7, 16'h0000));
        issueInstr(buildInstr(`OP_SW, 3, 6, 16'h0020));
        issueInstr(buildInstr(`OP_LW, 3, 8, 16'h0020));
        // Lane merges
        issueInstr(buildInstr(`OP_SW, 1, 0, 16'h0010));
        issueInstr(buildInstr(`OP_SB, 1, 5, 16'h0010));
        issueInstr(buildInstr(`OP_SB, 1, 6, 16'h0011));
        issueInstr(buildInstr(`OP_SH, 1, 6, 16'h0012));
        issueInstr(buildInstr(`OP_LW, 1, 7, 16'h0010));
        issueInstr(buildInstr(`OP_SW, 1, 0, 16'h0014));
        issueInstr(buildInstr(`OP_SH, 1, 6, 16'h0014));
        issueInstr(buildInstr(`OP_SB, 1, 6, 16'h0016));
        issueInstr(buildInstr(`OP_SB, 1, 5, 16'h0017));
        issueInstr(buildInstr(`OP_LW, 1, 7, 16'h0014));
        // Extension, byte 0x113 is 0x87
        issueInstr(buildInstr(`OP_LB, 1, 8, 16'h0013));
        issueInstr(buildInstr(`OP_LBU, 1, 8, 16'h0013));
        issueInstr(buildInstr(`OP_LH, 1, 8, 16'h0012));
        issueInstr(buildInstr(`OP_LHU, 1, 8, 16'h0012));
        issueInstr(buildInstr(`OP_LB, 1, 8, 16'h0010));
        // Misaligned accesses
        issueInstr(buildInstr(`OP_LH, 1, 9, 16'h0011));
        issueInstr(buildInstr(`OP_LW, 1, 9, 16'h0012));
        issueInstr(buildInstr(`OP_SW, 1, 5, 16'h0011));
        issueInstr(buildInstr(`OP_LW, 1, 9, 16'h0010));  // Word must be unchanged
        issueInstr(buildInstr(`OP_SH, 1, 5, 16'h0015));
        issueInstr(buildInstr(`OP_LW, 1, 9, 16'h0014));
    endtask

    initial begin
        void'($urandom(32'he49));
        rstN       = 1'b0;
        instr      = '0;
        instrValid = 1'b0;
        for (int i = 0; i < `NUM_REGS; i++)
            modelRegs[i] = '0;
        for (int i = 0; i < `MEM_WORDS * 4; i++)
            modelMem[i] = '0;
        repeat (ResetCycles) @(posedge Clock);
        @(negedge Clock);
        rstN = 1'b1;
        runDirected();
        for (int n = 0; n < NumRand; n++) begin
            if ($urandom % 8 == 0)
                idleCycle(randomInstr());
            else
                issueInstr(randomInstr());
        end
        @(negedge Clock);
        instrValid = 1'b0;
        repeat (2) @(negedge Clock);
        totalErrs = wordErrs + flagErrs + loadStoreUnit_i.lsuChk_i.failCount;
        $display("%0d cycles checked, %0d word errors, %0d flag errors, %0d assertion failures",
                 checkCount, wordErrs, flagErrs, loadStoreUnit_i.lsuChk_i.failCount);
        if (totalErrs == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(TimeoutNs);
        $display("Timeout: the instruction stream did not finish in %0d ns", TimeoutNs);
        $display("** FAIL **");
        $finish;
    end

endmodule

/* verification/lsu_chk.sv */
`timescale 1ns/1ps

module lsuChk import lsuPkg::*; (
    input logic  Clock,
    input logic  rstN,
    input logic  instrValid,
    input logic  regWrite,
    input logic  misaligned,
    input logic  wbFromMem,   // High for any load
    input word_t effAddr
);

    int failCount = 0;  // Failed assertions so far

    // Reset holds off all register writes
    noWriteInReset: assert property (@(posedge Clock) !rstN |-> !regWrite)
        else begin
            failCount++;
            $error("regWrite asserted while rstN low");
        end

    // Misaligned load must not reach the register file
    noMisalignedLoadWrite: assert property (@(posedge Clock) disable iff (!rstN)
        !(misaligned && wbFromMem && regWrite))
        else begin
            failCount++;
            $error("register write from a misaligned load");
        end

    // Address never floats on a live instruction
    addrKnown: assert property (@(posedge Clock) disable iff (!rstN)
        instrValid |-> !$isunknown(effAddr))
        else begin
            failCount++;
            $error("effAddr unknown with instrValid high");
        end

endmodule

bind loadStoreUnit lsuChk lsuChk_i (
    .Clock      (Clock),
    .rstN       (rstN),
    .instrValid (instrValid),
    .regWrite   (regWrite),
    .misaligned (misaligned),
    .wbFromMem  (wbFromMem),
    .effAddr    (effAddr)
);
